// ==== hdl/frame_pkg.sv ====
`default_nettype none

package frame_pkg;

	////////////////////////////////////////
	// Word and field widths

	// Bytes per memory word and per output beat
	localparam int WORD_BYTES = 8;

	// Frame length in bytes
	localparam int LEN_BITS = 11;

	// VLAN tag carried in the header word
	localparam int VLAN_BITS = 12;

	////////////////////////////////////////
	// Memory word views

	// Header word as written ahead of each frame
	typedef struct packed {
		logic [WORD_BYTES*8-VLAN_BITS-16-1:0]	reserved;
		logic [VLAN_BITS-1:0]					vlan;
		logic [15-LEN_BITS:0]					gap;
		logic [LEN_BITS-1:0]					len;
	} frame_hdr_t;

	// Same memory word seen as a header or as payload bytes
	typedef union packed {
		frame_hdr_t						hdr;
		logic [WORD_BYTES-1:0][7:0]		bytes;
	} frame_word_t;

	// Tag that travels with every memory read
	typedef enum logic {
		READ_HEADER,
		READ_BODY
	} read_kind_t;

endpackage

`default_nettype wire

// ==== hdl/frame_read_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface frame_read_if #(
	parameter int NUM_PORTS = 4,
	parameter int PORT_DEPTH = 64
);
	import frame_pkg::*;

	localparam int PORT_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
	localparam int ADDR_BITS = $clog2(PORT_DEPTH);

	// Request side, one read per cycle at most
	logic					req;
	logic [PORT_BITS-1:0]	req_port;
	logic [ADDR_BITS-1:0]	req_addr;
	read_kind_t				req_kind;

	// Response side, fixed latency after the request
	logic					rsp_valid;
	logic [PORT_BITS-1:0]	rsp_port;
	read_kind_t				rsp_kind;
	frame_word_t			rsp_data;

	modport requester(
		output req, req_port, req_addr, req_kind,
		input rsp_valid, rsp_port, rsp_kind, rsp_data
	);

	modport memory(
		input req, req_port, req_addr, req_kind,
		output rsp_valid, rsp_port, rsp_kind, rsp_data
	);

	modport observer(
		input req, req_port, req_addr, req_kind,
		input rsp_valid, rsp_port, rsp_kind, rsp_data
	);

endinterface

`default_nettype wire

// ==== hdl/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
	parameter int NUM_PORTS = 4,
	parameter int PORT_DEPTH = 64,
	parameter int READ_LATENCY = 2,
	localparam int PORT_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1,
	localparam int PTR_BITS = $clog2(PORT_DEPTH) + 1
) (
	input logic									clk,
	input logic									reset,

	// Writer side
	input logic									wr_en,
	input logic [PORT_BITS-1:0]					wr_port,
	input logic [frame_pkg::WORD_BYTES*8-1:0]	wr_data,
	input logic									commit,
	input logic [PORT_BITS-1:0]					commit_port,
	output logic [PTR_BITS-1:0]					committed_ptr [NUM_PORTS],

	// Reader side
	frame_read_if.memory						rd
);
	import frame_pkg::*;

	localparam int ADDR_BITS = $clog2(PORT_DEPTH);

	////////////////////////////////////////
	// Storage and pointers

	// One ring region per port, port index in the upper address bits
	logic [WORD_BYTES*8-1:0]	mem [NUM_PORTS*PORT_DEPTH];

	// Free-running write pointers, wrap bit on top
	logic [PTR_BITS-1:0]		wr_ptr [NUM_PORTS];

	// Read pipeline, stage 0 is the array output register
	logic [READ_LATENCY-1:0]	pipe_valid;
	logic [PORT_BITS-1:0]		pipe_port [READ_LATENCY];
	read_kind_t					pipe_kind [READ_LATENCY];
	frame_word_t				pipe_data [READ_LATENCY];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				wr_ptr[p]			<= '0;
				committed_ptr[p]	<= '0;
			end
			pipe_valid <= '0;
		end else begin
			if (wr_en)
				wr_ptr[wr_port] <= wr_ptr[wr_port] + 1'b1;

			// Publish everything written so far on this port
			if (commit)
				committed_ptr[commit_port] <= wr_ptr[commit_port];

			pipe_valid[0] <= rd.req;
			for (int i = 1; i < READ_LATENCY; i++)
				pipe_valid[i] <= pipe_valid[i-1];
		end
	end

	////////////////////////////////////////
	// Array access and payload pipeline

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[{wr_port, wr_ptr[wr_port][ADDR_BITS-1:0]}] <= wr_data;

		// Tag and data move together through every stage
		pipe_data[0] <= mem[{rd.req_port, rd.req_addr}];
		pipe_port[0] <= rd.req_port;
		pipe_kind[0] <= rd.req_kind;
		for (int i = 1; i < READ_LATENCY; i++) begin
			pipe_data[i] <= pipe_data[i-1];
			pipe_port[i] <= pipe_port[i-1];
			pipe_kind[i] <= pipe_kind[i-1];
		end
	end

	assign rd.rsp_valid	= pipe_valid[READ_LATENCY-1];
	assign rd.rsp_port	= pipe_port[READ_LATENCY-1];
	assign rd.rsp_kind	= pipe_kind[READ_LATENCY-1];
	assign rd.rsp_data	= pipe_data[READ_LATENCY-1];

endmodule

`default_nettype wire

// ==== hdl/port_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_scheduler #(
	parameter int NUM_PORTS = 4,
	parameter int PORT_DEPTH = 64,
	localparam int PORT_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1,
	localparam int PTR_BITS = $clog2(PORT_DEPTH) + 1
) (
	input logic					clk,
	input logic					reset,
	input logic [PTR_BITS-1:0]	committed_ptr [NUM_PORTS],
	input logic					issue_ok,
	frame_read_if.requester		rd
);
	import frame_pkg::*;

	localparam int ADDR_BITS = $clog2(PORT_DEPTH);
	localparam int SHIFT = $clog2(WORD_BYTES);
	localparam int WCNT_BITS = LEN_BITS - SHIFT + 1;

	typedef enum logic [1:0] {
		ST_SCAN,
		ST_HDR_WAIT,
		ST_BODY
	} sched_state_t;

	sched_state_t			state;
	logic [PORT_BITS-1:0]	scan_port;
	logic [PORT_BITS-1:0]	cur_port;
	logic [PORT_BITS-1:0]	sel_port;
	logic [PORT_BITS-1:0]	next_port;
	logic [PTR_BITS-1:0]	rd_ptr [NUM_PORTS];
	logic [WCNT_BITS-1:0]	words_left;
	logic [LEN_BITS:0]		hdr_round;
	logic					scan_hit;
	logic					body_go;
	logic					body_done;

	////////////////////////////////////////
	// Request decode

	// Port under test while scanning, frame owner otherwise
	assign sel_port = (state == ST_SCAN) ? scan_port : cur_port;
	assign next_port = (sel_port == PORT_BITS'(NUM_PORTS - 1)) ? '0 : sel_port + 1'b1;

	// Any committed word past the read pointer starts a frame
	assign scan_hit = (state == ST_SCAN) && (rd_ptr[scan_port] != committed_ptr[scan_port]);

	// Body reads only while the framer grants credit
	assign body_go = (state == ST_BODY) && issue_ok && (words_left != '0);
	assign body_done = (state == ST_BODY) &&
		((words_left == '0) || (body_go && (words_left == WCNT_BITS'(1))));

	// Byte length rounded up to whole words
	assign hdr_round = {1'b0, rd.rsp_data.hdr.len} + (LEN_BITS+1)'(WORD_BYTES - 1);

	assign rd.req		= scan_hit || body_go;
	assign rd.req_port	= sel_port;
	assign rd.req_kind	= (state == ST_SCAN) ? READ_HEADER : READ_BODY;
	// Address wraps inside the port region
	assign rd.req_addr	= rd_ptr[sel_port][ADDR_BITS-1:0];

	////////////////////////////////////////
	// FSM and read pointers

	always_ff @(posedge clk) begin
		if (reset) begin
			state		<= ST_SCAN;
			scan_port	<= '0;
			cur_port	<= '0;
			words_left	<= '0;
			for (int p = 0; p < NUM_PORTS; p++)
				rd_ptr[p] <= '0;
		end else begin
			// Every issued read consumes one word
			if (rd.req)
				rd_ptr[sel_port] <= rd_ptr[sel_port] + 1'b1;

			case (state)
				ST_SCAN: begin
					if (scan_hit) begin
						cur_port	<= scan_port;
						state		<= ST_HDR_WAIT;
					end else
						scan_port	<= next_port;
				end

				// Wait for the header to learn the body size
				ST_HDR_WAIT: begin
					if (rd.rsp_valid && (rd.rsp_kind == READ_HEADER)) begin
						words_left	<= hdr_round[LEN_BITS:SHIFT];
						state		<= ST_BODY;
					end
				end

				ST_BODY: begin
					if (body_go)
						words_left <= words_left - 1'b1;
					// Resume scanning after the port just served
					if (body_done) begin
						scan_port	<= next_port;
						state		<= ST_SCAN;
					end
				end

				default: state <= ST_SCAN;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/egress_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

module egress_framer #(
	parameter int NUM_PORTS = 4,
	parameter int OUT_DEPTH = 4,
	localparam int PORT_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
	input logic									clk,
	input logic									reset,
	frame_read_if.observer						rd,
	output logic								issue_ok,

	// Output stream
	output logic								tx_valid,
	input logic									tx_ready,
	output logic [frame_pkg::WORD_BYTES*8-1:0]	tx_data,
	output logic [frame_pkg::WORD_BYTES-1:0]	tx_keep,
	output logic								tx_last,
	output logic [PORT_BITS-1:0]				tx_port,
	output logic [frame_pkg::VLAN_BITS-1:0]		tx_vlan
);
	import frame_pkg::*;

	localparam int IDX_BITS = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
	localparam int CNT_BITS = $clog2(OUT_DEPTH + 1);

	// Output queue entries
	logic [WORD_BYTES*8-1:0]	q_data [OUT_DEPTH];
	logic [WORD_BYTES-1:0]		q_keep [OUT_DEPTH];
	logic						q_last [OUT_DEPTH];
	logic [PORT_BITS-1:0]		q_port [OUT_DEPTH];
	logic [VLAN_BITS-1:0]		q_vlan [OUT_DEPTH];

	logic [IDX_BITS-1:0]		wr_idx;
	logic [IDX_BITS-1:0]		rd_idx;
	logic [CNT_BITS-1:0]		q_count;
	logic [CNT_BITS-1:0]		outstanding;
	logic [CNT_BITS:0]			credit_used;
	logic [LEN_BITS-1:0]		bytes_left;
	logic [VLAN_BITS-1:0]		cur_vlan;
	logic [WORD_BYTES-1:0]		new_keep;
	logic						new_last;
	logic						push;
	logic						pop;
	logic						body_req;

	assign push		= rd.rsp_valid && (rd.rsp_kind == READ_BODY);
	assign pop		= tx_valid && tx_ready;
	assign body_req	= rd.req && (rd.req_kind == READ_BODY);

	// Reads in flight count against the queue space
	assign credit_used	= q_count + outstanding;
	assign issue_ok		= credit_used < (CNT_BITS+1)'(OUT_DEPTH);

	////////////////////////////////////////
	// Keep and last for the arriving word

	always_comb begin
		if (bytes_left > LEN_BITS'(WORD_BYTES)) begin
			new_keep = '1;
			new_last = 1'b0;
		end else begin
			// Low bytes only on the tail word
			new_keep = {WORD_BYTES{1'b1}} >> (WORD_BYTES - bytes_left);
			new_last = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_idx		<= '0;
			rd_idx		<= '0;
			q_count		<= '0;
			outstanding	<= '0;
			bytes_left	<= '0;
		end else begin
			if (rd.rsp_valid && (rd.rsp_kind == READ_HEADER))
				bytes_left <= rd.rsp_data.hdr.len;
			else if (push)
				bytes_left <= new_last ? '0 : bytes_left - LEN_BITS'(WORD_BYTES);

			if (push)
				wr_idx <= (wr_idx == IDX_BITS'(OUT_DEPTH - 1)) ? '0 : wr_idx + 1'b1;
			if (pop)
				rd_idx <= (rd_idx == IDX_BITS'(OUT_DEPTH - 1)) ? '0 : rd_idx + 1'b1;

			case ({push, pop})
				2'b10: q_count <= q_count + 1'b1;
				2'b01: q_count <= q_count - 1'b1;
				default: q_count <= q_count;
			endcase

			case ({body_req, push})
				2'b10: outstanding <= outstanding + 1'b1;
				2'b01: outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	////////////////////////////////////////
	// Queue payload

	always_ff @(posedge clk) begin
		// VLAN held until the next header arrives
		if (rd.rsp_valid && (rd.rsp_kind == READ_HEADER))
			cur_vlan <= rd.rsp_data.hdr.vlan;
		if (push) begin
			q_data[wr_idx]	<= rd.rsp_data.bytes;
			q_keep[wr_idx]	<= new_keep;
			q_last[wr_idx]	<= new_last;
			q_port[wr_idx]	<= rd.rsp_port;
			q_vlan[wr_idx]	<= cur_vlan;
		end
	end

	// Head entry drives the stream and holds until popped
	assign tx_valid	= q_count != '0;
	assign tx_data	= q_data[rd_idx];
	assign tx_keep	= q_keep[rd_idx];
	assign tx_last	= q_last[rd_idx];
	assign tx_port	= q_port[rd_idx];
	assign tx_vlan	= q_vlan[rd_idx];

endmodule

`default_nettype wire

// ==== hdl/fifo_reader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_reader_top #(
	parameter int NUM_PORTS = 4,
	parameter int PORT_DEPTH = 64,
	parameter int READ_LATENCY = 2,
	parameter int OUT_DEPTH = 4,
	localparam int PORT_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
	input logic									clk,
	input logic									reset,

	// Frame memory load
	input logic									wr_en,
	input logic [PORT_BITS-1:0]					wr_port,
	input logic [frame_pkg::WORD_BYTES*8-1:0]	wr_data,
	input logic									commit,
	input logic [PORT_BITS-1:0]					commit_port,

	// Egress stream
	output logic								tx_valid,
	input logic									tx_ready,
	output logic [frame_pkg::WORD_BYTES*8-1:0]	tx_data,
	output logic [frame_pkg::WORD_BYTES-1:0]	tx_keep,
	output logic								tx_last,
	output logic [PORT_BITS-1:0]				tx_port,
	output logic [frame_pkg::VLAN_BITS-1:0]		tx_vlan
);

	localparam int PTR_BITS = $clog2(PORT_DEPTH) + 1;

	logic [PTR_BITS-1:0]	committed_ptr [NUM_PORTS];
	logic					issue_ok;

	// Shared read path between scheduler, buffer and framer
	frame_read_if #(
		.NUM_PORTS(NUM_PORTS),
		.PORT_DEPTH(PORT_DEPTH)
	) rd_bus ();

	frame_buffer #(
		.NUM_PORTS(NUM_PORTS),
		.PORT_DEPTH(PORT_DEPTH),
		.READ_LATENCY(READ_LATENCY)
	) buffer (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_port(wr_port),
		.wr_data(wr_data),
		.commit(commit),
		.commit_port(commit_port),
		.committed_ptr(committed_ptr),
		.rd(rd_bus.memory)
	);

	port_scheduler #(
		.NUM_PORTS(NUM_PORTS),
		.PORT_DEPTH(PORT_DEPTH)
	) scheduler (
		.clk(clk),
		.reset(reset),
		.committed_ptr(committed_ptr),
		.issue_ok(issue_ok),
		.rd(rd_bus.requester)
	);

	egress_framer #(
		.NUM_PORTS(NUM_PORTS),
		.OUT_DEPTH(OUT_DEPTH)
	) framer (
		.clk(clk),
		.reset(reset),
		.rd(rd_bus.observer),
		.issue_ok(issue_ok),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.tx_data(tx_data),
		.tx_keep(tx_keep),
		.tx_last(tx_last),
		.tx_port(tx_port),
		.tx_vlan(tx_vlan)
	);

endmodule

`default_nettype wire

// ==== tb/fifo_reader_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_reader_props #(
	parameter int READ_LATENCY = 2,
	parameter int PORT_BITS = 2
) (
	input logic					clk,
	input logic					reset,
	input logic					req,
	input logic					rsp_valid,
	input logic					tx_valid,
	input logic					tx_ready,
	input logic [63:0]			tx_data,
	input logic [7:0]			tx_keep,
	input logic					tx_last,
	input logic [PORT_BITS-1:0]	tx_port,
	input logic [11:0]			tx_vlan
);

	////////////////////////////////////////
	// Output stream

	// Stalled beat holds every field
	stall_hold: assert property (@(posedge clk) disable iff (reset)
		(tx_valid && !tx_ready) |=>
			(tx_valid && $stable({tx_data, tx_keep, tx_last, tx_port, tx_vlan})))
		else $error("Output beat changed or dropped while tx_ready was low");

	// Keep runs up from bit 0 with no holes
	keep_shape: assert property (@(posedge clk) disable iff (reset)
		tx_valid |-> (tx_keep[0] && ((tx_keep & (tx_keep + 1'b1)) == '0)))
		else $error("tx_keep %h is not a contiguous low-byte mask", tx_keep);

	////////////////////////////////////////
	// Read interface

	// One response per request, fixed delay
	read_latency: assert property (@(posedge clk) disable iff (reset)
		rsp_valid == $past(req, READ_LATENCY))
		else $error("rsp_valid does not follow req by %0d cycles", READ_LATENCY);

endmodule

bind fifo_reader_top fifo_reader_props #(
	.READ_LATENCY(READ_LATENCY),
	.PORT_BITS(PORT_BITS)
) props (
	.clk(clk),
	.reset(reset),
	.req(rd_bus.req),
	.rsp_valid(rd_bus.rsp_valid),
	.tx_valid(tx_valid),
	.tx_ready(tx_ready),
	.tx_data(tx_data),
	.tx_keep(tx_keep),
	.tx_last(tx_last),
	.tx_port(tx_port),
	.tx_vlan(tx_vlan)
);

`default_nettype wire

// ==== tb/tb_fifo_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fifo_reader;

	localparam int NUM_PORTS = 4;
	localparam int PORT_DEPTH = 64;
	localparam int READ_LATENCY = 2;
	localparam int OUT_DEPTH = 4;
	// Longest body is 200 bytes
	localparam int MAX_BODY = 25;
	localparam int MAX_FRAME = MAX_BODY + 1;
	// Upper bound on header plus body words over all five tests
	localparam int MAX_WORDS = 9 + 10 + 4 * MAX_FRAME + 40 * MAX_FRAME + 20 * MAX_FRAME;
	localparam int WATCHDOG_CYCLES = MAX_WORDS * 20 + 2000;
	localparam int SHORT_LENS [4] = '{1, 7, 9, 13};
	localparam int MIXED_LENS [4] = '{40, 17, 64, 3};

	// Expected output beat
	typedef struct packed {
		logic [63:0]	data;
		logic [7:0]		keep;
		logic			last;
		logic [11:0]	vlan;
	} beat_t;

	logic			clk = 1'b0;
	logic			reset;
	logic			wr_en;
	logic [1:0]		wr_port;
	logic [63:0]	wr_data;
	logic			commit;
	logic [1:0]		commit_port;
	logic			tx_valid;
	logic			tx_ready = 1'b1;
	logic [63:0]	tx_data;
	logic [7:0]		tx_keep;
	logic			tx_last;
	logic [1:0]		tx_port;
	logic [11:0]	tx_vlan;

	int				seed = 32'h9216;
	bit				bp_on = 1'b0;
	int				errors = 0;
	int				checks = 0;
	// Words loaded per port and not yet seen at the output
	int				pending_words [NUM_PORTS] = '{default: 0};
	beat_t			exp_q [NUM_PORTS][$];
	logic [63:0]	frame_words [MAX_BODY];
	bit				in_frame = 1'b0;
	logic [1:0]		frame_port = '0;

	fifo_reader_top #(
		.NUM_PORTS(NUM_PORTS),
		.PORT_DEPTH(PORT_DEPTH),
		.READ_LATENCY(READ_LATENCY),
		.OUT_DEPTH(OUT_DEPTH)
	) UUT (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_port(wr_port),
		.wr_data(wr_data),
		.commit(commit),
		.commit_port(commit_port),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.tx_data(tx_data),
		.tx_keep(tx_keep),
		.tx_last(tx_last),
		.tx_port(tx_port),
		.tx_vlan(tx_vlan)
	);

	initial begin
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////
	// Reference model

	// Beat idx of a frame whose body sits in frame_words
	function automatic beat_t expected_beat(input int len, input logic [11:0] vlan,
			input int idx);
		beat_t	b;
		int		remaining;
		remaining = len - idx * 8;
		b.data = frame_words[idx];
		// Low bytes valid up to the bytes left in the frame
		for (int i = 0; i < 8; i++)
			b.keep[i] = (i < remaining);
		b.last = (idx == (len + 7) / 8 - 1);
		b.vlan = vlan;
		return b;
	endfunction

	function automatic bit queues_empty();
		for (int p = 0; p < NUM_PORTS; p++)
			if (exp_q[p].size() != 0)
				return 1'b0;
		return 1'b1;
	endfunction

	////////////////////////////////////////
	// Stimulus tasks

	task automatic load_frame(input int port, input int len, input logic [11:0] vlan,
			input bit do_commit);
		int nwords;
		nwords = (len + 7) / 8;
		// Hold off until the ring region has room
		while (pending_words[port] + 1 + nwords > PORT_DEPTH)
			@(negedge clk);
		pending_words[port] += 1 + nwords;
		// Tail bytes past len are random too
		for (int i = 0; i < nwords; i++) begin
			frame_words[i] = {$random(seed), $random(seed)};
			exp_q[port].push_back(expected_beat(len, vlan, i));
		end
		@(negedge clk);
		wr_en = 1'b1;
		wr_port = port[1:0];
		// Header with len in 10:0 and vlan in 27:16
		wr_data = {36'h0, vlan, 5'h0, len[10:0]};
		for (int i = 0; i < nwords; i++) begin
			@(negedge clk);
			wr_data = frame_words[i];
		end
		@(negedge clk);
		wr_en = 1'b0;
		if (do_commit) begin
			commit = 1'b1;
			commit_port = port[1:0];
			@(negedge clk);
			commit = 1'b0;
		end
	endtask

	// Commits every port on consecutive cycles
	task automatic commit_back_to_back();
		for (int p = 0; p < NUM_PORTS; p++) begin
			@(negedge clk);
			commit = 1'b1;
			commit_port = p[1:0];
		end
		@(negedge clk);
		commit = 1'b0;
	endtask

	task automatic wait_drained();
		while (!queues_empty())
			@(negedge clk);
		// Room for any stray extra beat to show up
		repeat (20) @(negedge clk);
	endtask

	task automatic report_test(input int num, input string name, input int start_err);
		$display("test %0d %s: %0d errors", num, name, errors - start_err);
	endtask

	////////////////////////////////////////
	// Back-pressure and comparison

	always @(negedge clk) begin
		if (bp_on)
			tx_ready <= (($random(seed) & 32'd1) != 0);
		else
			tx_ready <= 1'b1;
	end

	always @(posedge clk) begin
		beat_t want;
		if (!reset && tx_valid && tx_ready) begin
			checks++;
			assert (!in_frame || tx_port == frame_port) else begin
				$display("Beat from port %0d broke into a frame from port %0d",
					tx_port, frame_port);
				errors++;
			end
			assert (exp_q[tx_port].size() != 0) else begin
				$display("Beat on port %0d arrived with no frame expected", tx_port);
				errors++;
			end
			if (exp_q[tx_port].size() != 0) begin
				want = exp_q[tx_port].pop_front();
				assert (tx_data == want.data) else begin
					$display("mismatch tx_data: got %h expected %h", tx_data, want.data);
					errors++;
				end
				assert (tx_keep == want.keep) else begin
					$display("mismatch tx_keep: got %h expected %h", tx_keep, want.keep);
					errors++;
				end
				assert (tx_last == want.last) else begin
					$display("mismatch tx_last: got %h expected %h", tx_last, want.last);
					errors++;
				end
				assert (tx_vlan == want.vlan) else begin
					$display("mismatch tx_vlan: got %h expected %h", tx_vlan, want.vlan);
					errors++;
				end
			end
			// Header word freed with the last beat
			pending_words[tx_port] -= tx_last ? 2 : 1;
			in_frame = !tx_last;
			frame_port = tx_port;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles with frames still pending",
			WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

	////////////////////////////////////////
	// Test sequence

	initial begin
		int start_err;
		int port;
		int len;
		reset = 1'b1;
		wr_en = 1'b0;
		wr_port = '0;
		wr_data = '0;
		commit = 1'b0;
		commit_port = '0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		start_err = errors;
		load_frame(0, 64, 12'h101, 1'b1);
		wait_drained();
		report_test(1, "single 64-byte frame", start_err);

		start_err = errors;
		for (int i = 0; i < 4; i++)
			load_frame(1, SHORT_LENS[i], 12'h300 + 12'(i), 1'b1);
		wait_drained();
		report_test(2, "partial keep lengths", start_err);

		// Frames parked on every port, then released together
		start_err = errors;
		for (int p = 0; p < NUM_PORTS; p++)
			load_frame(p, MIXED_LENS[p], 12'h200 + 12'(p), 1'b0);
		commit_back_to_back();
		wait_drained();
		report_test(3, "all ports at once", start_err);

		start_err = errors;
		bp_on = 1'b1;
		for (int i = 0; i < 40; i++) begin
			port = {$random(seed)} % NUM_PORTS;
			len = 1 + {$random(seed)} % 200;
			load_frame(port, len, 12'($random(seed)), 1'b1);
		end
		wait_drained();
		bp_on = 1'b0;
		report_test(4, "random back-pressure", start_err);

		// Serial frames on one port run its ring around several times
		start_err = errors;
		for (int i = 0; i < 20; i++) begin
			len = 64 + {$random(seed)} % 137;
			load_frame(3, len, 12'h3c0 + 12'(i), 1'b1);
			wait_drained();
		end
		report_test(5, "ring wrap on port 3", start_err);

		$display("beats checked: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/frame_pkg.sv
hdl/frame_read_if.sv
hdl/frame_buffer.sv
hdl/port_scheduler.sv
hdl/egress_framer.sv
hdl/fifo_reader_top.sv
tb/fifo_reader_props.sv
tb/tb_fifo_reader.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the frame reader testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module tb_fifo_reader -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
